//--- filelist.f
verilog/fetch_pkg.sv
verilog/next_pc_select.sv
verilog/instr_mem.sv
verilog/fetch_stage.sv
verilog/fetch_unit.sv
dv/fetch_tb.sv

//--- run.sh
#!/bin/sh
# build the fetch unit testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module fetch_tb -f filelist.f -o fetch_sim \
  && ./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

grep -q "^All tests passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- dv/fetch_tests.txt
// columns: op arg0 arg1 arg2, all hex; op 0 load (index data), 1 run (count)
// op 2 run with hold (count max_hold), 3 redirect (mask max_offset), 4 address (sel addr)
// op 5 redirect under hold (mask), f end (run_count redirect_count); mask trap mret jump fence
0 08 0093 0
0 09 0010 0
0 0a 4505 0
0 0b 0113 0
0 0c 0020 0
0 0d 0505 0
0 0e 8082 0
0 0f 0193 0
0 10 0030 0
0 11 0213 0
0 12 0040 0
0 13 4601 0
0 14 0293 0
0 15 0050 0
0 16 0001 0
0 21 0413 0
0 22 0080 0
0 30 4701 0
0 31 0393 0
0 32 0070 0
0 40 0313 0
0 41 0060 0
0 42 4681 0
0 50 0009 0
0 51 0493 0
0 52 0090 0
4 0 00000080 0
4 1 00000060 0
4 2 00000042 0
4 3 000000a0 0
1 0a 0 0
3 8 4 0
1 3 0 0
3 4 4 0
1 3 0 0
3 2 4 0
1 2 0 0
3 1 4 0
1 3 0 0
3 c 3 0
3 6 3 0
3 3 3 0
3 7 3 0
3 f 3 0
2 14 4 0
4 2 00000010 0
5 2 0 0
1 5 0 0
5 9 0 0
2 0c 3 0
f 3a b 0

//--- dv/fetch_tb.sv
module fetch_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import fetch_pkg::*;

  localparam addr_t reset_pc    = 32'h0000_0010;
  localparam int    mem_depth   = 128;
  localparam int    mem_latency = 3;
  localparam int    idx_w       = $clog2(mem_depth);
  localparam int    max_words   = 512;

  logic             clock;
  logic             reset;
  logic             trap;
  logic             mret;
  logic             jump;
  logic             fence;
  addr_t            mtvec;
  addr_t            mepc;
  addr_t            jump_addr;
  addr_t            fence_npc;
  logic             hold;
  logic             load_en;
  logic [idx_w-1:0] load_addr;
  half_t            load_data;
  logic             out_valid;
  addr_t            out_pc;
  instr_t           out_instr;

  // reference copy of the loaded memory
  half_t            model_mem [mem_depth];
  logic [31:0]      cmd_words [max_words];
  int               cmd_count;
  int               budget;

  // reference model state, updated by the monitor
  logic             checking;
  addr_t            exp_pc;
  instr_t           want_instr;
  int               issued;

  fetch_unit #(
    .reset_pc    (reset_pc),
    .mem_depth   (mem_depth),
    .mem_latency (mem_latency)
  ) i_fetch_unit (
    .clock     (clock),
    .reset     (reset),
    .trap      (trap),
    .mret      (mret),
    .jump      (jump),
    .fence     (fence),
    .mtvec     (mtvec),
    .mepc      (mepc),
    .jump_addr (jump_addr),
    .fence_npc (fence_npc),
    .hold      (hold),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .out_valid (out_valid),
    .out_pc    (out_pc),
    .out_instr (out_instr)
  );

  always #5 clock = ~clock;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_addr(input string name, input addr_t got, input addr_t want);
    if (got !== want) begin
      fail_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  task automatic compare_instr(input string name, input instr_t got, input instr_t want);
    if (got !== want) begin
      fail_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  task automatic compare_count(input string name, input int got, input int want);
    if (got != want) begin
      fail_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  // unloaded halfwords, all compressed, built from the whole index
  function automatic half_t fill_half(input int idx);
    logic [6:0] i;
    i = 7'(idx);
    return {i ^ 7'h5a, i, 2'b01};
  endfunction

  // two halfwords starting at pc, as the memory returns them
  function automatic instr_t expected_instr(input addr_t pc);
    int idx;
    idx = int'(pc[idx_w:1]);
    return {model_mem[(idx + 1) % mem_depth], model_mem[idx]};
  endfunction

  // trap over mret over jump over fence
  function automatic addr_t redirect_target();
    if (trap) begin
      return mtvec;
    end else if (mret) begin
      return mepc;
    end else if (jump) begin
      return jump_addr;
    end
    return fence_npc;
  endfunction

  always @(negedge clock) begin
    if (checking) begin
      if (hold && out_valid) begin
        fail_run("an instruction was issued while hold was high");
      end
      if (out_valid) begin
        want_instr = expected_instr(exp_pc);
        compare_addr("out_pc", out_pc, exp_pc);
        compare_instr("out_instr", out_instr, want_instr);
        exp_pc = exp_pc + ((want_instr[1:0] == 2'b11) ? 32'd4 : 32'd2);
        issued++;
      end else begin
        compare_instr("out_instr", out_instr, nop_instr);
      end
      if (trap || mret || jump || fence) begin
        exp_pc = redirect_target();
      end
    end
  end

  // limit worked out from the commands, armed once the file is parsed
  initial begin
    wait (budget > 0);
    repeat (budget) @(posedge clock);
    fail_run("the run took longer than the watchdog limit");
  end

  task automatic run_for(input int count);
    int goal;
    goal = issued + count;
    while (issued < goal) begin
      @(posedge clock);
    end
  endtask

  task automatic run_with_hold(input int count, input int max_len);
    int goal;
    int burst_left;
    int gap_left;
    goal       = issued + count;
    burst_left = 0;
    gap_left   = 0;
    while (issued < goal) begin
      @(posedge clock);
      if (burst_left > 0) begin
        hold <= 1'b1;
        burst_left--;
      end else if (gap_left > 0) begin
        hold <= 1'b0;
        gap_left--;
      end else if ($urandom % 4 == 0) begin
        hold       <= 1'b1;
        burst_left = int'($urandom % max_len);
        // low gap lets at least one instruction through per burst
        gap_left   = mem_latency + 1;
      end else begin
        hold <= 1'b0;
      end
    end
    hold <= 1'b0;
  endtask

  task automatic pulse_redirect(input logic [3:0] mask);
    trap  <= mask[3];
    mret  <= mask[2];
    jump  <= mask[1];
    fence <= mask[0];
    @(posedge clock);
    trap  <= 1'b0;
    mret  <= 1'b0;
    jump  <= 1'b0;
    fence <= 1'b0;
  endtask

  task automatic redirect_now(input logic [3:0] mask, input int max_offset);
    int offset;
    offset = int'($urandom % (max_offset + 1));
    repeat (offset) @(posedge clock);
    @(posedge clock);
    pulse_redirect(mask);
    run_for(1);
  endtask

  // park an instruction under hold, then redirect over it
  task automatic redirect_in_hold(input logic [3:0] mask);
    @(posedge clock);
    hold <= 1'b1;
    repeat (mem_latency + 2) @(posedge clock);
    pulse_redirect(mask);
    repeat (2) @(posedge clock);
    hold <= 1'b0;
    run_for(1);
  endtask

  task automatic set_address(input int sel, input addr_t addr);
    @(posedge clock);
    case (sel)
      0: mtvec <= addr;
      1: mepc <= addr;
      2: jump_addr <= addr;
      default: fence_npc <= addr;
    endcase
  endtask

  initial begin
    int          start;
    int          run_issued;
    int          redirects;
    int          want_runs;
    int          want_redirects;
    int          cycles;
    logic [31:0] op;
    logic [31:0] a0;
    logic [31:0] a1;
    clock     = 1'b0;
    reset     = 1'b0;
    trap      = 1'b0;
    mret      = 1'b0;
    jump      = 1'b0;
    fence     = 1'b0;
    mtvec     = '0;
    mepc      = '0;
    jump_addr = '0;
    fence_npc = '0;
    hold      = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    checking  = 1'b0;
    exp_pc    = reset_pc;
    issued    = 0;
    budget    = 0;
    void'($urandom(32'h82aa42d3));

    for (int i = 0; i < max_words; i++) begin
      cmd_words[i] = '1;
    end
    for (int i = 0; i < mem_depth; i++) begin
      model_mem[i] = fill_half(i);
    end
    $readmemh("dv/fetch_tests.txt", cmd_words);

    // first pass: program halfwords and the cycle budget
    cycles         = mem_depth + 200;
    cmd_count      = 0;
    want_runs      = 0;
    want_redirects = 0;
    while (cmd_count < max_words / 4 && cmd_words[4 * cmd_count] != 32'hf) begin
      op = cmd_words[4 * cmd_count];
      a0 = cmd_words[4 * cmd_count + 1];
      a1 = cmd_words[4 * cmd_count + 2];
      case (op)
        0: model_mem[int'(a0) % mem_depth] = half_t'(a1);
        1: cycles += int'(a0) * (mem_latency + 1);
        2: cycles += int'(a0) * (int'(a1) + 2 * mem_latency + 3);
        3: cycles += int'(a1) + 2 * mem_latency + 6;
        5: cycles += 4 * mem_latency + 10;
        default: cycles += 2;
      endcase
      cmd_count++;
    end
    if (cmd_count == max_words / 4) begin
      fail_run("the test file has no end command");
    end
    want_runs      = int'(cmd_words[4 * cmd_count + 1]);
    want_redirects = int'(cmd_words[4 * cmd_count + 2]);
    budget         = cycles;

    // memory loads while reset is low
    for (int i = 0; i < mem_depth; i++) begin
      @(posedge clock);
      load_en   <= 1'b1;
      load_addr <= idx_w'(i);
      load_data <= model_mem[i];
    end
    @(posedge clock);
    load_en <= 1'b0;
    repeat (2) @(posedge clock);
    reset    <= 1'b1;
    checking = 1'b1;

    run_issued = 0;
    redirects  = 0;
    for (int k = 0; k < cmd_count; k++) begin
      op = cmd_words[4 * k];
      a0 = cmd_words[4 * k + 1];
      a1 = cmd_words[4 * k + 2];
      start = issued;
      case (op)
        0: begin
        end
        1: begin
          run_for(int'(a0));
          run_issued += issued - start;
        end
        2: begin
          run_with_hold(int'(a0), int'(a1));
          run_issued += issued - start;
        end
        3: begin
          redirect_now(a0[3:0], int'(a1));
          redirects++;
        end
        4: set_address(int'(a0), a1);
        5: begin
          redirect_in_hold(a0[3:0]);
          redirects++;
        end
        default: fail_run($sformatf("unknown command %0d in the test file", op));
      endcase
    end

    if (run_issued == want_runs && redirects == want_redirects) begin
      $display("All tests passed");
      $finish;
    end else begin
      compare_count("run_issued", run_issued, want_runs);
      compare_count("redirects", redirects, want_redirects);
    end
  end

endmodule

//--- verilog/fetch_unit.sv
module fetch_unit #(
  parameter fetch_pkg::addr_t reset_pc    = 32'h0000_0000,
  parameter int               mem_depth   = 1024,
  parameter int               mem_latency = 3
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         trap,
  input  logic                         mret,
  input  logic                         jump,
  input  logic                         fence,
  input  fetch_pkg::addr_t             mtvec,
  input  fetch_pkg::addr_t             mepc,
  input  fetch_pkg::addr_t             jump_addr,
  input  fetch_pkg::addr_t             fence_npc,
  input  logic                         hold,
  input  logic                         load_en,
  input  logic [$clog2(mem_depth)-1:0] load_addr,
  input  fetch_pkg::half_t             load_data,
  output logic                         out_valid,
  output fetch_pkg::addr_t             out_pc,
  output fetch_pkg::instr_t            out_instr
);

  import fetch_pkg::*;

  addr_t           cur_pc;
  instr_t          cur_instr;
  redirect_cause_t cause;
  addr_t           target;

  // memory request channel
  logic            req;
  addr_t           req_addr;
  logic            ready;
  instr_t          rdata;

  fetch_stage #(
    .reset_pc (reset_pc)
  ) i_fetch_stage (
    .clock     (clock),
    .reset     (reset),
    .hold      (hold),
    .ready     (ready),
    .rdata     (rdata),
    .cause     (cause),
    .target    (target),
    .cur_pc    (cur_pc),
    .cur_instr (cur_instr),
    .req       (req),
    .req_addr  (req_addr),
    .out_valid (out_valid),
    .out_pc    (out_pc),
    .out_instr (out_instr)
  );

  next_pc_select i_next_pc_select (
    .trap      (trap),
    .mret      (mret),
    .jump      (jump),
    .fence     (fence),
    .mtvec     (mtvec),
    .mepc      (mepc),
    .jump_addr (jump_addr),
    .fence_npc (fence_npc),
    .cur_pc    (cur_pc),
    .cur_instr (cur_instr),
    .cause     (cause),
    .target    (target)
  );

  instr_mem #(
    .mem_depth   (mem_depth),
    .mem_latency (mem_latency)
  ) i_instr_mem (
    .clock     (clock),
    .reset     (reset),
    .req       (req),
    .req_addr  (req_addr),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .ready     (ready),
    .rdata     (rdata)
  );

endmodule

//--- verilog/fetch_stage.sv
module fetch_stage #(
  parameter fetch_pkg::addr_t reset_pc = 32'h0000_0000
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       hold,
  input  logic                       ready,
  input  fetch_pkg::instr_t          rdata,
  input  fetch_pkg::redirect_cause_t cause,
  input  fetch_pkg::addr_t           target,
  output fetch_pkg::addr_t           cur_pc,
  output fetch_pkg::instr_t          cur_instr,
  output logic                       req,
  output fetch_pkg::addr_t           req_addr,
  output logic                       out_valid,
  output fetch_pkg::addr_t           out_pc,
  output fetch_pkg::instr_t          out_instr
);

  import fetch_pkg::*;

  fetch_state_t state;
  fetch_state_t state_next;

  // pc of the outstanding or next request
  addr_t        pc;
  addr_t        pc_next;

  // instruction parked while hold is high
  logic         held_valid;
  logic         held_valid_next;
  instr_t       held_instr;

  logic         redirect;

  assign redirect = (cause != cause_none);

  always_comb begin
    state_next      = state;
    pc_next         = pc;
    held_valid_next = held_valid;
    req             = 1'b0;
    out_valid       = 1'b0;
    case (state)
      fetch_idle: begin
        if (redirect) begin
          // nothing in flight, target goes out next cycle
          pc_next         = target;
          held_valid_next = 1'b0;
        end else if (held_valid) begin
          if (!hold) begin
            out_valid       = 1'b1;
            req             = 1'b1;
            pc_next         = target;
            held_valid_next = 1'b0;
            state_next      = fetch_wait;
          end
        end else begin
          req        = 1'b1;
          state_next = fetch_wait;
        end
      end
      fetch_wait: begin
        if (redirect) begin
          pc_next = target;
          if (ready) begin
            // returning word is from the old path, drop it
            req = 1'b1;
          end else begin
            state_next = fetch_discard;
          end
        end else if (ready) begin
          if (hold) begin
            held_valid_next = 1'b1;
            state_next      = fetch_idle;
          end else begin
            out_valid = 1'b1;
            req       = 1'b1;
            pc_next   = target;
          end
        end
      end
      fetch_discard: begin
        // speculative request, its data is never issued
        if (redirect) begin
          pc_next = target;
        end
        if (ready) begin
          req        = 1'b1;
          state_next = fetch_wait;
        end
      end
      default: begin
        state_next = fetch_idle;
      end
    endcase
  end

  // sequential successor when issuing, redirect target otherwise
  assign req_addr = (redirect || out_valid) ? target : pc;

  assign cur_pc    = pc;
  assign cur_instr = held_valid ? held_instr : rdata;

  assign out_pc    = pc;
  assign out_instr = out_valid ? cur_instr : nop_instr;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state      <= fetch_idle;
      pc         <= reset_pc;
      held_valid <= 1'b0;
    end else begin
      state      <= state_next;
      pc         <= pc_next;
      held_valid <= held_valid_next;
    end
  end

  always_ff @(posedge clock) begin
    if (state == fetch_wait && ready) begin
      held_instr <= rdata;
    end
  end

endmodule

//--- verilog/instr_mem.sv
module instr_mem #(
  parameter int mem_depth   = 1024,
  parameter int mem_latency = 3
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         req,
  input  fetch_pkg::addr_t             req_addr,
  input  logic                         load_en,
  input  logic [$clog2(mem_depth)-1:0] load_addr,
  input  fetch_pkg::half_t             load_data,
  output logic                         ready,
  output fetch_pkg::instr_t            rdata
);

  import fetch_pkg::*;

  localparam int idx_w = $clog2(mem_depth);

  half_t            mem [mem_depth];

  // request delay line, one entry per cycle of latency
  logic [mem_latency-1:0] valid_q;
  logic [idx_w-1:0]       idx_q [mem_latency];

  logic [idx_w-1:0]       idx_lo;
  logic [idx_w-1:0]       idx_hi;

  // load port, only used while fetch is quiet
  always_ff @(posedge clock) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= req;
      for (int i = 1; i < mem_latency; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // byte address to halfword index
  always_ff @(posedge clock) begin
    idx_q[0] <= req_addr[idx_w:1];
    for (int i = 1; i < mem_latency; i++) begin
      idx_q[i] <= idx_q[i-1];
    end
  end

  assign idx_lo = idx_q[mem_latency-1];

  // second halfword wraps at the end of the array
  assign idx_hi = (idx_lo == idx_w'(mem_depth - 1)) ? '0 : idx_lo + 1'b1;

  assign ready = valid_q[mem_latency-1];

  // two halfwords so a misaligned 32-bit instruction comes back whole
  assign rdata = {mem[idx_hi], mem[idx_lo]};

endmodule

//--- verilog/next_pc_select.sv
module next_pc_select (
  input  logic                       trap,
  input  logic                       mret,
  input  logic                       jump,
  input  logic                       fence,
  input  fetch_pkg::addr_t           mtvec,
  input  fetch_pkg::addr_t           mepc,
  input  fetch_pkg::addr_t           jump_addr,
  input  fetch_pkg::addr_t           fence_npc,
  input  fetch_pkg::addr_t           cur_pc,
  input  fetch_pkg::instr_t          cur_instr,
  output fetch_pkg::redirect_cause_t cause,
  output fetch_pkg::addr_t           target
);

  import fetch_pkg::*;

  addr_t seq_pc;
  logic  is_full;

  // low bits 11 mark a 32-bit instruction, anything else is compressed
  assign is_full = (cur_instr[1:0] == 2'b11);

  assign seq_pc = cur_pc + (is_full ? 32'd4 : 32'd2);

  // fixed priority: trap, mret, jump, fence
  always_comb begin
    cause  = cause_none;
    target = seq_pc;
    if (trap) begin
      cause  = cause_trap;
      target = mtvec;
    end else if (mret) begin
      cause  = cause_mret;
      target = mepc;
    end else if (jump) begin
      cause  = cause_jump;
      target = jump_addr;
    end else if (fence) begin
      // refetch everything after the fence
      cause  = cause_fence;
      target = fence_npc;
    end
  end

endmodule

//--- verilog/fetch_pkg.sv
package fetch_pkg;

  // byte address into the instruction space
  typedef logic [31:0] addr_t;

  // one memory halfword
  typedef logic [15:0] half_t;

  // full instruction word
  // a compressed instruction only uses bits 15:0
  typedef logic [31:0] instr_t;

  // fetch control states
  typedef enum logic [1:0] {
    fetch_idle,
    fetch_wait,
    fetch_discard
  } fetch_state_t;

  // winning redirect source, highest priority first after none
  typedef enum logic [2:0] {
    cause_none,
    cause_trap,
    cause_mret,
    cause_jump,
    cause_fence
  } redirect_cause_t;

  // addi x0,x0,0
  localparam instr_t nop_instr = 32'h0000_0013;

endpackage
